// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - files:
      - hw/mips_pkg.sv
      - hw/mips_decode.sv
      - hw/mips_regfile.sv
      - hw/mips_alu.sv
      - hw/mips_next_pc.sv
      - hw/mips_bus_ctrl.sv
      - hw/mips_cpu_bus.sv
  - target: test
    files:
      - testbench/tb_mips_mem.sv
      - testbench/tb_mips_cpu_bus.sv

// File: all.f
hw/mips_pkg.sv
hw/mips_decode.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_next_pc.sv
hw/mips_bus_ctrl.sv
hw/mips_cpu_bus.sv
testbench/tb_mips_mem.sv
testbench/tb_mips_cpu_bus.sv

// File: hw/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    result,
    output logic               equal
);
    import mips_pkg::*;

    word_t op_b;
    logic  lt_signed;
    logic  lt_unsigned;

    // Immediate forms, loads and stores use the extended immediate
    assign op_b = dec.use_imm ? dec.imm : rt_data;

    assign lt_signed   = $signed(rs_data) < $signed(op_b);
    assign lt_unsigned = rs_data < op_b;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  result = rs_data + op_b;
            ALU_SUB:  result = rs_data - op_b;
            ALU_AND:  result = rs_data & op_b;
            ALU_OR:   result = rs_data | op_b;
            ALU_XOR:  result = rs_data ^ op_b;
            ALU_LUI:  result = {op_b[15:0], 16'h0000};
            ALU_SLT:  result = {31'd0, lt_signed};
            ALU_SLTU: result = {31'd0, lt_unsigned};
            // Shifts act on rt by the shamt field
            ALU_SLL:  result = rt_data << dec.shamt;
            ALU_SRL:  result = rt_data >> dec.shamt;
            ALU_SRA:  result = word_t'($signed(rt_data) >>> dec.shamt);
            default:  result = rs_data + op_b;
        endcase
    end

    // Branch compare always on the two register values
    assign equal = (rs_data == rt_data);

endmodule

// File: hw/mips_bus_ctrl.sv
`timescale 1ns/1ps

module mips_bus_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               waitrequest,
    input  mips_pkg::word_t    readdata,
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    alu_result,
    input  mips_pkg::word_t    rt_data,
    input  mips_pkg::word_t    pc,
    output mips_pkg::word_t    instr,
    output logic               read,
    output logic               write,
    output mips_pkg::word_t    address,
    output mips_pkg::word_t    writedata,
    output logic [3:0]         byteenable,
    output mips_pkg::reg_wr_t  reg_wr,
    output logic               pc_advance,
    output logic               active
);
    import mips_pkg::*;

    cpu_state_e state_q;
    cpu_state_e state_d;
    logic       read_q;
    logic       read_d;
    logic       write_q;
    logic       write_d;
    logic       active_q;
    logic       fetch_done;
    logic       halt;
    word_t      instr_q;
    word_t      link_addr;

    assign link_addr = pc + 32'd4;
    // jr passes rs through the ALU, zero target stops the core
    assign halt       = dec.is_jr && (alu_result == '0);
    assign fetch_done = (state_q == ST_FETCH) && read_q && !waitrequest;

    always_comb begin
        state_d    = state_q;
        read_d     = read_q;
        write_d    = write_q;
        pc_advance = 1'b0;
        reg_wr     = '0;
        reg_wr.idx = dec.rd;
        case (state_q)
            ST_FETCH: begin
                // First cycle sets up the address, then read is held
                if (!read_q) begin
                    read_d = 1'b1;
                end else if (!waitrequest) begin
                    read_d  = 1'b0;
                    state_d = ST_EXECUTE;
                end
            end
            ST_EXECUTE: begin
                if (dec.is_load || dec.is_store) begin
                    read_d  = dec.is_load;
                    write_d = dec.is_store;
                    state_d = ST_MEMORY;
                end else begin
                    reg_wr.en   = dec.reg_write;
                    reg_wr.data = dec.link ? link_addr : alu_result;
                    pc_advance  = 1'b1;
                    state_d     = halt ? ST_HALTED : ST_FETCH;
                end
            end
            ST_MEMORY: begin
                // Strobe and ALU address stay put while waitrequest is high
                if (!waitrequest) begin
                    read_d      = 1'b0;
                    write_d     = 1'b0;
                    reg_wr.en   = dec.is_load;
                    reg_wr.data = readdata;
                    pc_advance  = 1'b1;
                    state_d     = ST_FETCH;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= ST_FETCH;
            read_q   <= 1'b0;
            write_q  <= 1'b0;
            active_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            read_q   <= read_d;
            write_q  <= write_d;
            active_q <= (state_d != ST_HALTED);
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr_q <= readdata;
        end
    end

    assign instr      = instr_q;
    assign read       = read_q;
    assign write      = write_q;
    assign address    = (state_q == ST_MEMORY) ? alu_result : pc;
    assign writedata  = rt_data;
    // Word accesses only
    assign byteenable = (read_q || write_q) ? 4'b1111 : 4'b0000;
    assign active     = active_q;

endmodule

// File: hw/mips_cpu_bus.sv
`timescale 1ns/1ps

module mips_cpu_bus #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,
    input  logic            waitrequest,
    input  mips_pkg::word_t readdata,
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable
);
    import mips_pkg::*;

    word_t    instr;
    decoded_t dec;
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_result;
    logic     equal;
    word_t    pc;
    reg_wr_t  reg_wr;
    logic     pc_advance;

    // Controller owns the bus and the instruction register
    mips_bus_ctrl u_bus_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .dec         (dec),
        .alu_result  (alu_result),
        .rt_data     (rt_data),
        .pc          (pc),
        .instr       (instr),
        .read        (read),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .reg_wr      (reg_wr),
        .pc_advance  (pc_advance),
        .active      (active)
    );

    mips_decode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (dec.rs),
        .rt_idx  (dec.rt),
        .reg_wr  (reg_wr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .dec     (dec),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .result  (alu_result),
        .equal   (equal)
    );

    // Link value is formed in the controller from pc
    mips_next_pc #(
        .RESET_PC (RESET_PC)
    ) u_next_pc (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (pc_advance),
        .dec      (dec),
        .equal    (equal),
        .rs_data  (rs_data),
        .pc       (pc),
        .pc_plus4 ()
    );

endmodule

// File: hw/mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
    input  mips_pkg::word_t    instr,
    output mips_pkg::decoded_t dec
);
    import mips_pkg::*;

    opcode_e opcode;
    funct_e  funct;
    word_t   sign_imm;
    word_t   zero_imm;
    word_t   jump_index;

    assign opcode     = opcode_e'(instr[31:26]);
    assign funct      = funct_e'(instr[5:0]);
    assign sign_imm   = {{16{instr[15]}}, instr[15:0]};
    assign zero_imm   = {16'h0000, instr[15:0]};
    assign jump_index = {6'b000000, instr[25:0]};

    always_comb begin
        // Defaults give a no-op that only advances the PC
        dec        = '0;
        dec.rs     = instr[25:21];
        dec.rt     = instr[20:16];
        dec.rd     = instr[15:11];
        dec.shamt  = instr[10:6];
        dec.imm    = sign_imm;
        dec.alu_op = ALU_ADD;
        case (opcode)
            OP_SPECIAL: begin
                dec.reg_write = 1'b1;
                case (funct)
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    FN_SRA:  dec.alu_op = ALU_SRA;
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_JR: begin
                        // ALU passes rs through so the controller sees the target
                        dec.reg_write = 1'b0;
                        dec.is_jr     = 1'b1;
                        dec.use_imm   = 1'b1;
                        dec.imm       = '0;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_J: begin
                dec.is_jump = 1'b1;
                dec.imm     = jump_index;
            end
            OP_JAL: begin
                dec.is_jump   = 1'b1;
                dec.link      = 1'b1;
                dec.reg_write = 1'b1;
                dec.rd        = 5'd31;
                dec.imm       = jump_index;
            end
            OP_BEQ: dec.is_beq = 1'b1;
            OP_BNE: dec.is_bne = 1'b1;
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.rd        = instr[20:16];
                case (opcode)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    // sltiu still sign-extends, then compares unsigned
                    OP_SLTIU: dec.alu_op = ALU_SLTU;
                    OP_ANDI:  dec.alu_op = ALU_AND;
                    OP_ORI:   dec.alu_op = ALU_OR;
                    OP_XORI:  dec.alu_op = ALU_XOR;
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    default:  dec.alu_op = ALU_ADD;
                endcase
                // Logic immediates are zero-extended
                if (opcode inside {OP_ANDI, OP_ORI, OP_XORI}) begin
                    dec.imm = zero_imm;
                end
            end
            OP_LW: begin
                dec.is_load   = 1'b1;
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.rd        = instr[20:16];
            end
            OP_SW: begin
                dec.is_store = 1'b1;
                dec.use_imm  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/mips_next_pc.sv
`timescale 1ns/1ps

module mips_next_pc #(
    parameter mips_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               advance,
    input  mips_pkg::decoded_t dec,
    input  logic               equal,
    input  mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    pc,
    output mips_pkg::word_t    pc_plus4
);
    import mips_pkg::*;

    word_t pc_q;
    word_t branch_target;
    word_t jump_target;
    logic  take_branch;

    assign pc_plus4 = pc_q + 32'd4;

    // Offset counted in words from the following instruction
    assign branch_target = pc_plus4 + {dec.imm[29:0], 2'b00};
    // Jump stays inside the current 256 MB region
    assign jump_target   = {pc_plus4[31:28], dec.imm[25:0], 2'b00};
    assign take_branch   = (dec.is_beq && equal) || (dec.is_bne && !equal);

    // No delay slot, target taken directly
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (advance) begin
            if (dec.is_jr) begin
                pc_q <= rs_data;
            end else if (dec.is_jump) begin
                pc_q <= jump_target;
            end else if (take_branch) begin
                pc_q <= branch_target;
            end else begin
                pc_q <= pc_plus4;
            end
        end
    end

    assign pc = pc_q;

endmodule

// File: hw/mips_pkg.sv
package mips_pkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Primary opcodes of the kept subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function codes under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXECUTE,
        ST_MEMORY,
        ST_HALTED
    } cpu_state_e;

    // Everything later stages need from one instruction
    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;        // Final destination, rt or 31 already resolved
        word_t    imm;       // Extended immediate, or jump index for j/jal
        logic [4:0] shamt;
        alu_op_e  alu_op;
        logic     use_imm;   // Second ALU operand is imm
        logic     reg_write;
        logic     is_load;
        logic     is_store;
        logic     is_beq;
        logic     is_bne;
        logic     is_jump;
        logic     is_jr;
        logic     link;      // Write PC+4 instead of ALU result
    } decoded_t;

    // Single write-back port into the register file
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } reg_wr_t;

endpackage

// File: hw/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::reg_wr_t  reg_wr,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    word_t regs [32];

    // Single write port, register zero never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr.en && (reg_wr.idx != 5'd0)) begin
            regs[reg_wr.idx] <= reg_wr.data;
        end
    end

    // Asynchronous reads
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    // Observation tap on $v0
    assign v0 = regs[2];

endmodule

// File: testbench/tb_mips_cpu_bus.sv
`timescale 1ns/1ps

module tb_mips_cpu_bus;
    import mips_pkg::*;

    localparam word_t MEM_BASE         = 32'h0000_1000;
    localparam int    MEM_WORDS        = 256;
    localparam word_t DATA_ADDR        = 32'h0000_1200;
    localparam int    MAX_TESTS        = 8;
    localparam int    MAX_WORDS        = 16;
    localparam int    RESET_CYCLES     = 16;
    // Fetch and data transfer each stall at most three cycles
    localparam int    MAX_INSTR_CYCLES = 10;
    localparam int    MARGIN_CYCLES    = 20;
    localparam int    HALT_WINDOW      = 8;

    // Register names
    localparam reg_idx_t ZERO = 5'd0;
    localparam reg_idx_t V0   = 5'd2;
    localparam reg_idx_t A0   = 5'd4;
    localparam reg_idx_t A1   = 5'd5;
    localparam reg_idx_t A2   = 5'd6;
    localparam reg_idx_t T0   = 5'd8;
    localparam reg_idx_t T1   = 5'd9;
    localparam reg_idx_t T2   = 5'd10;
    localparam reg_idx_t T3   = 5'd11;
    localparam reg_idx_t RA   = 5'd31;

    logic       clk;
    logic       rst_n;
    logic       active;
    logic       read;
    logic       write;
    logic       waitrequest;
    logic [3:0] byteenable;
    word_t      address;
    word_t      readdata;
    word_t      writedata;
    word_t      register_v0;

    // Test table
    string names     [MAX_TESTS];
    word_t progs     [MAX_TESTS][MAX_WORDS];
    int    n_words   [MAX_TESTS];
    word_t exp_v0    [MAX_TESTS];
    word_t data_addr [MAX_TESTS];
    word_t exp_data  [MAX_TESTS];
    int    n_tests;
    int    cur;

    int    value_errors;
    int    other_errors;
    logic  timed_out;

    mips_cpu_bus #(
        .RESET_PC (MEM_BASE)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .register_v0 (register_v0),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .address     (address),
        .write       (write),
        .read        (read),
        .writedata   (writedata),
        .byteenable  (byteenable)
    );

    tb_mips_mem #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk         (clk),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // Instruction encoders
    function automatic word_t r_type(input logic [5:0] funct, input reg_idx_t rs,
                                     input reg_idx_t rt, input reg_idx_t rd,
                                     input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_idx_t rs,
                                     input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input logic [5:0] op, input word_t target);
        return {op, target[27:2]};
    endfunction

    // Background word, mixes every address bit
    function automatic word_t fill_word(input word_t addr);
        return ~addr ^ {addr[7:0], addr[31:8]};
    endfunction

    task automatic begin_test(input string name, input word_t v0, input word_t addr,
                              input word_t data);
        cur            = n_tests;
        n_tests        = n_tests + 1;
        names[cur]     = name;
        exp_v0[cur]    = v0;
        data_addr[cur] = addr;
        exp_data[cur]  = data;
        n_words[cur]   = 0;
    endtask

    task automatic emit(input word_t instr_word);
        if (n_words[cur] >= MAX_WORDS) begin
            $display("Test %s: program longer than %0d words", names[cur], MAX_WORDS);
            other_errors++;
        end else begin
            progs[cur][n_words[cur]] = instr_word;
            n_words[cur] = n_words[cur] + 1;
        end
    endtask

    task automatic build_table();
        n_tests = 0;
        // 100 + (-30) = 70, 70 - (-30) = 100, 100 << 4 = 1600, 1600 + 70 = 0x686
        begin_test("alu_arith", 32'h0000_0686, DATA_ADDR, fill_word(DATA_ADDR));
        emit(i_type(OP_ADDIU, ZERO, T0, 16'd100));
        emit(i_type(OP_ADDIU, ZERO, T1, 16'hffe2));
        emit(r_type(FN_ADDU, T0, T1, T2, 5'd0));
        emit(r_type(FN_SUBU, T2, T1, T3, 5'd0));
        emit(r_type(FN_SLL, ZERO, T3, T3, 5'd4));
        emit(r_type(FN_ADDU, T3, T2, V0, 5'd0));
        emit(r_type(FN_JR, ZERO, ZERO, ZERO, 5'd0));
        // andi zero-extends 0xff00, result 0x1234ffff ^ 0xf000 & 0x1234f0f0
        begin_test("alu_logic", 32'h1234_00f0, DATA_ADDR, fill_word(DATA_ADDR));
        emit(i_type(OP_LUI, ZERO, T0, 16'h1234));
        emit(i_type(OP_ORI, T0, T0, 16'hf0f0));
        emit(i_type(OP_ANDI, T0, T1, 16'hff00));
        emit(i_type(OP_XORI, T1, T2, 16'h0fff));
        emit(r_type(FN_OR, T2, T0, T3, 5'd0));
        emit(r_type(FN_XOR, T3, T1, T3, 5'd0));
        emit(r_type(FN_AND, T3, T0, V0, 5'd0));
        emit(r_type(FN_JR, ZERO, ZERO, ZERO, 5'd0));
        // slt=1, sltu=0 (weight 8), slti=1 (weight 2), sltiu=1 (weight 4)
        begin_test("shift_compare", 32'h0000_0007, DATA_ADDR, fill_word(DATA_ADDR));
        emit(i_type(OP_LUI, ZERO, T0, 16'h8000));
        emit(r_type(FN_SRA, ZERO, T0, T1, 5'd4));
        emit(r_type(FN_SRL, ZERO, T0, T2, 5'd4));
        emit(r_type(FN_SLT, T1, T2, T3, 5'd0));
        emit(r_type(FN_SLTU, T1, T2, A0, 5'd0));
        emit(i_type(OP_SLTI, T1, A1, 16'hffff));
        emit(i_type(OP_SLTIU, T2, A2, 16'hffff));
        emit(r_type(FN_SLL, ZERO, A1, A1, 5'd1));
        emit(r_type(FN_SLL, ZERO, A2, A2, 5'd2));
        emit(r_type(FN_SLL, ZERO, A0, A0, 5'd3));
        emit(r_type(FN_ADDU, T3, A1, V0, 5'd0));
        emit(r_type(FN_ADDU, V0, A2, V0, 5'd0));
        emit(r_type(FN_ADDU, V0, A0, V0, 5'd0));
        emit(r_type(FN_JR, ZERO, ZERO, ZERO, 5'd0));
        // Store at base+8, load back through a negative offset
        begin_test("mem_roundtrip", 32'hcafe_babe, DATA_ADDR + 32'd8, 32'hcafe_babe);
        emit(i_type(OP_ADDIU, ZERO, T0, 16'h1200));
        emit(i_type(OP_LUI, ZERO, T1, 16'hcafe));
        emit(i_type(OP_ORI, T1, T1, 16'hbabe));
        emit(i_type(OP_SW, T0, T1, 16'h0008));
        emit(i_type(OP_ADDIU, T0, T2, 16'h0010));
        emit(i_type(OP_LW, T2, V0, 16'hfff8));
        emit(r_type(FN_JR, ZERO, ZERO, ZERO, 5'd0));
        // Taken branches skip weights 1 and 16, so 2 + 4 + 8 + 32
        begin_test("branches", 32'h0000_002e, DATA_ADDR, fill_word(DATA_ADDR));
        emit(i_type(OP_ADDIU, ZERO, T0, 16'd5));
        emit(i_type(OP_ADDIU, ZERO, T1, 16'd5));
        emit(i_type(OP_ADDIU, ZERO, V0, 16'd0));
        emit(i_type(OP_BEQ, T0, T1, 16'h0001));
        emit(i_type(OP_ADDIU, V0, V0, 16'd1));
        emit(i_type(OP_ADDIU, V0, V0, 16'd2));
        emit(i_type(OP_BNE, T0, T1, 16'h0001));
        emit(i_type(OP_ADDIU, V0, V0, 16'd4));
        emit(i_type(OP_ADDIU, ZERO, T1, 16'd7));
        emit(i_type(OP_BEQ, T0, T1, 16'h0001));
        emit(i_type(OP_ADDIU, V0, V0, 16'd8));
        emit(i_type(OP_BNE, T0, T1, 16'h0001));
        emit(i_type(OP_ADDIU, V0, V0, 16'd16));
        emit(i_type(OP_ADDIU, V0, V0, 16'd32));
        emit(r_type(FN_JR, ZERO, ZERO, ZERO, 5'd0));
        // 1, subroutine adds 0x10, return adds 0x100, word 4 never runs
        begin_test("jump_link", 32'h0000_0111, DATA_ADDR, fill_word(DATA_ADDR));
        emit(i_type(OP_ADDIU, ZERO, V0, 16'h0001));
        emit(j_type(OP_JAL, MEM_BASE + 32'd20));
        emit(i_type(OP_ADDIU, V0, V0, 16'h0100));
        emit(j_type(OP_J, MEM_BASE + 32'd28));
        emit(i_type(OP_ADDIU, V0, V0, 16'h1000));
        emit(i_type(OP_ADDIU, V0, V0, 16'h0010));
        emit(r_type(FN_JR, RA, ZERO, ZERO, 5'd0));
        emit(r_type(FN_JR, ZERO, ZERO, ZERO, 5'd0));
        // $zero ignores the write, so both v0 and the stored word are zero
        begin_test("zero_register", 32'h0000_0000, DATA_ADDR, 32'h0000_0000);
        emit(i_type(OP_ADDIU, ZERO, ZERO, 16'd55));
        emit(i_type(OP_ADDIU, ZERO, V0, 16'd9));
        emit(i_type(OP_ADDIU, ZERO, T0, 16'h1200));
        emit(i_type(OP_SW, T0, ZERO, 16'h0000));
        emit(r_type(FN_ADDU, ZERO, ZERO, V0, 5'd0));
        emit(r_type(FN_JR, ZERO, ZERO, ZERO, 5'd0));
    endtask

    // Background pattern everywhere, then the program from the base
    task automatic load_program(input int t);
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_mem.write_word(MEM_BASE + 32'(4 * i), fill_word(MEM_BASE + 32'(4 * i)));
        end
        for (int i = 0; i < n_words[t]; i++) begin
            u_mem.write_word(MEM_BASE + 32'(4 * i), progs[t][i]);
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic check_v0(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: v0 expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_mem(input string name, input word_t addr, input word_t expected,
                             input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: mem[%h] expected %h, actual %h", name, addr, expected, actual);
            value_errors++;
        end
    endtask

    // Halted core keeps active and both strobes low
    task automatic watch_halted(input string name);
        int bad;
        bad = 0;
        repeat (HALT_WINDOW) begin
            @(negedge clk);
            if (active !== 1'b0 || read !== 1'b0 || write !== 1'b0) begin
                bad++;
            end
        end
        if (bad != 0) begin
            $display("Test %s: core left the halted state in %0d of %0d cycles",
                     name, bad, HALT_WINDOW);
            other_errors++;
        end
    endtask

    task automatic run_test(input int t);
        int   cycles;
        int   limit;
        logic halted;
        load_program(t);
        apply_reset();
        cycles = 0;
        halted = 1'b0;
        limit  = n_words[t] * MAX_INSTR_CYCLES + MARGIN_CYCLES;
        // Wait for active to drop after the jr to zero
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (!active) begin
                halted = 1'b1;
            end
        end
        if (!halted) begin
            $display("Test %s: core never halted within %0d cycles", names[t], limit);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            check_v0(names[t], exp_v0[t], register_v0);
            check_mem(names[t], data_addr[t], exp_data[t], u_mem.read_word(data_addr[t]));
            watch_halted(names[t]);
        end
    endtask

    initial begin
        int total_other;
        rst_n        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        build_table();
        // A timeout ends the run early
        for (int t = 0; t < n_tests && !timed_out; t++) begin
            run_test(t);
        end
        total_other = other_errors + u_mem.bus_errors;
        $display("Summary: %0d tests, %0d value errors, %0d other errors",
                 n_tests, value_errors, total_other);
        if (value_errors == 0 && total_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/tb_mips_mem.sv
`timescale 1ns/1ps

module tb_mips_mem #(
    parameter mips_pkg::word_t MEM_BASE  = 32'h0000_1000,
    parameter int              MEM_WORDS = 256
) (
    input  logic            clk,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    output mips_pkg::word_t readdata,
    output logic            waitrequest
);
    import mips_pkg::*;

    word_t      mem [MEM_WORDS];
    logic [1:0] wait_cnt;
    integer     seed;
    int         bus_errors;
    // Bus state seen at the last stalled edge
    logic       stalled;
    word_t      held_addr;
    word_t      held_data;
    logic       held_write;

    initial begin
        seed        = 32'hcadf;
        bus_errors  = 0;
        wait_cnt    = 2'd0;
        stalled     = 1'b0;
        readdata    = '0;
        waitrequest = 1'b0;
    end

    function automatic int word_index(input word_t addr);
        return int'((addr - MEM_BASE) >> 2);
    endfunction

    function automatic logic in_range(input word_t addr);
        return (addr - MEM_BASE) < word_t'(MEM_WORDS * 4);
    endfunction

    // Backdoor access for preload and result checks
    function automatic word_t read_word(input word_t addr);
        return mem[word_index(addr)];
    endfunction

    task automatic write_word(input word_t addr, input word_t data);
        mem[word_index(addr)] = data;
    endtask

    // Responses change only on the falling edge
    always @(negedge clk) begin
        if (read || write) begin
            waitrequest <= (wait_cnt != 2'd0);
            readdata    <= in_range(address) ? mem[word_index(address)] : 'x;
        end else begin
            waitrequest <= 1'b0;
        end
    end

    always @(posedge clk) begin
        // A stalled transfer must come back unchanged
        if (stalled && (!(read || write) || address !== held_addr
                || write !== held_write || (write && writedata !== held_data))) begin
            $display("Bus error: core changed the transfer at %h during waitrequest", held_addr);
            bus_errors++;
        end
        stalled = 1'b0;
        if (read && write) begin
            $display("Bus error: read and write high together at %h", address);
            bus_errors++;
        end
        if (read || write) begin
            if (waitrequest) begin
                wait_cnt   <= wait_cnt - 2'd1;
                stalled    = 1'b1;
                held_addr  = address;
                held_data  = writedata;
                held_write = write;
            end else begin
                if (!in_range(address)) begin
                    $display("Bus error: access outside memory at %h", address);
                    bus_errors++;
                end else begin
                    // Loads, stores and fetches are all whole words
                    if (byteenable !== 4'b1111) begin
                        $display("Bus error: partial byteenable %b on word access",
                                 byteenable);
                        bus_errors++;
                    end
                    if (write) begin
                        mem[word_index(address)] = writedata;
                    end
                end
                // Wait length for the next transfer, 0 to 3 cycles
                wait_cnt <= 2'($random(seed));
            end
        end
    end

endmodule
